// File: verilog.f
src/video_pkg.sv
src/timing_if.sv
src/pixel_fifo_if.sv
src/video_timing.sv
src/pixel_fifo.sv
src/video_out.sv
src/video_top.sv
verif/video_sva.sv
verif/video_tb.sv

// File: verif/video_tb.sv
/* Testbench for the video subsystem. A random host spends credits while a cycle
   model of the raster and FIFO predicts every registered output */
`timescale 1ns/1ps
`default_nettype none

module video_tb;
        import video_pkg::*;

        localparam int clk_period = 40;
        localparam int reset_cycles = 16;
        localparam int line_cycles = h_last - h_start + 1;
        localparam int frame_cycles = line_cycles * (v_last - v_start + 1);
        localparam int run_cycles = (frame_cycles * 5) / 2;
        // Three frames plus a hundred lines of slack for reset and drain
        localparam int timeout_ns = (3 * frame_cycles + 100 * line_cycles) * clk_period;

        logic clk;
        logic rst_n;
        logic in_valid;
        logic [pix_w-1:0] in_pixel;
        logic credit;
        logic [pix_w-1:0] rgb;
        logic hsync_n;
        logic vsync_n;
        logic blank;
        logic underflow;

        // Model raster state, mirrors the counter registers
        logic [cnt_w-1:0] m_h;
        logic [cnt_w-1:0] m_v;
        logic m_vblk;
        int m_count;
        logic [pix_w-1:0] exp_q[$];

        // Outputs expected after the next rising edge
        logic [pix_w-1:0] exp_rgb;
        logic exp_hsync_n;
        logic exp_vsync_n;
        logic exp_blank;
        logic exp_underflow;
        logic exp_credit;

        integer seed;
        int host_credits;
        int pops;
        int credit_pulses;
        int cycle;
        int drain_cycles;

        video_top i_video_top (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_pixel  (in_pixel),
                .credit    (credit),
                .rgb       (rgb),
                .hsync_n   (hsync_n),
                .vsync_n   (vsync_n),
                .blank     (blank),
                .underflow (underflow)
        );

        initial begin
                clk = 1'b0;
                forever #(clk_period / 2) clk = ~clk;
        end

        // ====================================================================
        // Error reporting
        // ====================================================================

        task automatic fail_run(input string reason);
                $display("%s", reason);
                $display("STATUS: FAIL");
                $fatal(1, "Simulation stopped on the first error");
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                           name, got, expected));
                end
        endtask

        // ====================================================================
        // One clock of compare, host drive and model update
        // ====================================================================

        // Called on a falling edge, returns on the next one
        task automatic step_cycle(input bit dense, input bit allow_send);
                logic active;
                logic m_empty;
                logic do_pop;
                logic do_send;
                logic [pix_w-1:0] pixel;
                check_value("rgb", rgb, exp_rgb);
                check_value("hsync_n", hsync_n, exp_hsync_n);
                check_value("vsync_n", vsync_n, exp_vsync_n);
                check_value("blank", blank, exp_blank);
                check_value("underflow", underflow, exp_underflow);
                check_value("credit", credit, exp_credit);
                if (credit) begin
                        host_credits++;
                        credit_pulses++;
                end
                if (host_credits < 0 || host_credits > fifo_depth) begin
                        fail_run("Host credit count left the range from zero to the FIFO depth");
                end
                // Active window and pop follow the raster position held now
                active = !m_vblk && (m_h >= h_active_first);
                m_empty = (m_count == 0);
                do_pop = active && !m_empty;
                exp_rgb = do_pop ? exp_q[0] : '0;
                exp_hsync_n = !((m_h >= hsync_first) && (m_h <= hsync_last));
                exp_vsync_n = m_v[cnt_w-1];
                exp_blank = !active;
                exp_underflow = active && m_empty;
                exp_credit = do_pop;
                // Sparse sending starves the display, dense sending fills it
                do_send = 1'b0;
                if (allow_send && host_credits > 0) begin
                        if (dense) begin
                                do_send = (($random(seed) & 3) != 0);
                        end else begin
                                do_send = (($random(seed) & 7) == 0);
                        end
                end
                pixel = '0;
                if (do_send) begin
                        pixel = $random(seed);
                        host_credits--;
                        m_count++;
                        exp_q.push_back(pixel);
                end
                in_valid = do_send;
                in_pixel = pixel;
                if (do_pop) begin
                        void'(exp_q.pop_front());
                        m_count--;
                        pops++;
                end
                // Blank reads the line number before the vertical step
                if (m_h == h_vblk_upd) begin
                        if (m_v == v_blank_off) begin
                                m_vblk = 1'b0;
                        end else if (m_v == v_blank_on) begin
                                m_vblk = 1'b1;
                        end
                end
                if (m_h == h_vstep) begin
                        m_v = (m_v == v_last) ? v_start : m_v + 1'b1;
                end
                m_h = (m_h == h_last) ? h_start : m_h + 1'b1;
                @(negedge clk);
        endtask

        // ====================================================================
        // Main sequence
        // ====================================================================

        initial begin
                seed = 32'h7cb3473e;
                rst_n = 1'b0;
                in_valid = 1'b0;
                in_pixel = '0;
                m_h = h_start;
                m_v = v_start;
                m_vblk = 1'b1;
                m_count = 0;
                host_credits = fifo_depth;
                pops = 0;
                credit_pulses = 0;
                drain_cycles = 0;
                // Reset values of the registered outputs
                exp_rgb = '0;
                exp_hsync_n = 1'b1;
                exp_vsync_n = 1'b1;
                exp_blank = 1'b1;
                exp_underflow = 1'b0;
                exp_credit = 1'b0;
                repeat (reset_cycles) @(negedge clk);
                rst_n = 1'b1;
                for (cycle = 0; cycle < run_cycles; cycle++) begin
                        step_cycle(cycle >= frame_cycles, 1'b1);
                end
                // Stop sending and give every credit half a frame to come home
                while (host_credits < fifo_depth && drain_cycles < frame_cycles / 2) begin
                        step_cycle(1'b1, 1'b0);
                        drain_cycles++;
                end
                step_cycle(1'b1, 1'b0);
                check_value("host_credits", host_credits, fifo_depth);
                check_value("credit_pulses", credit_pulses, pops);
                check_value("expected_queue_size", exp_q.size(), 0);
                $display("STATUS: PASS");
                $finish;
        end

        initial begin
                #(timeout_ns);
                fail_run("Timeout: the run did not finish within three frames plus margin");
        end

endmodule

`default_nettype wire

// File: verif/video_sva.sv
/* Concurrent checks on raster counter ranges, FIFO occupancy and credit state.
   Bound into the top level where the timing and FIFO links are visible */
`timescale 1ns/1ps
`default_nettype none

module video_sva (
        input logic clk,
        input logic rst_n,
        input logic [video_pkg::cnt_w-1:0] h_cnt,
        input logic [video_pkg::cnt_w-1:0] v_cnt,
        input logic [video_pkg::fifo_aw:0] level,
        input logic pop,
        input logic empty,
        input logic credit
);
        import video_pkg::*;

        // Both counters stay inside their odd arcade ranges
        a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
                (h_cnt >= h_start) && (h_cnt <= h_last))
                else $error("Horizontal count outside %0d..%0d", h_start, h_last);

        a_v_range: assert property (@(posedge clk) disable iff (!rst_n)
                (v_cnt >= v_start) && (v_cnt <= v_last))
                else $error("Vertical count outside %0d..%0d", v_start, v_last);

        // Host credits bound the occupancy
        a_level_max: assert property (@(posedge clk) disable iff (!rst_n)
                level <= fifo_depth)
                else $error("FIFO occupancy above its depth");

        a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
                pop |-> !empty)
                else $error("Pop issued while the FIFO was empty");

        // First edge after release sees the reset state of the FIFO
        a_reset_values: assert property (@(posedge clk)
                $rose(rst_n) |-> (!credit && empty))
                else $error("Credit or empty wrong just after reset");

endmodule

bind video_top video_sva i_video_sva (
        .clk    (clk),
        .rst_n  (rst_n),
        .h_cnt  (tim_if.h_cnt),
        .v_cnt  (tim_if.v_cnt),
        .level  (fifo_if.level),
        .pop    (fifo_if.pop),
        .empty  (fifo_if.empty),
        .credit (credit)
);

`default_nettype wire

// File: src/video_top.sv
/* Top level of the video subsystem. Host credit port in, registered raster video out.
   Ties the timing generator, line FIFO and output stage together */
`timescale 1ns/1ps
`default_nettype none

module video_top (
        input  logic clk,
        input  logic rst_n,
        input  logic in_valid,
        input  logic [video_pkg::pix_w-1:0] in_pixel,
        output logic credit,
        output logic [video_pkg::pix_w-1:0] rgb,
        output logic hsync_n,
        output logic vsync_n,
        output logic blank,
        output logic underflow
);

        // ====================================================================
        // Internal links
        // ====================================================================

        timing_if tim_if ();
        pixel_fifo_if fifo_if ();

        // ====================================================================
        // Blocks
        // ====================================================================

        // Raster position and flags
        video_timing i_video_timing (
                .clk   (clk),
                .rst_n (rst_n),
                .tim   (tim_if.src)
        );

        // Host writes land here and come back as credits
        pixel_fifo i_pixel_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_valid (in_valid),
                .in_pixel (in_pixel),
                .credit   (credit),
                .fq       (fifo_if.fifo)
        );

        // Consumes pixels in step with the raster
        video_out i_video_out (
                .clk       (clk),
                .rst_n     (rst_n),
                .tim       (tim_if.dst),
                .fq        (fifo_if.consumer),
                .rgb       (rgb),
                .hsync_n   (hsync_n),
                .vsync_n   (vsync_n),
                .blank     (blank),
                .underflow (underflow)
        );

endmodule

`default_nettype wire

// File: src/video_out.sv
/* Output stage. Pops one pixel per active clock and registers colour, syncs,
   blank and underflow so all outputs trail the raster by one clock */
`timescale 1ns/1ps
`default_nettype none

module video_out (
        input  logic clk,
        input  logic rst_n,
        timing_if.dst tim,
        pixel_fifo_if.consumer fq,
        output logic [video_pkg::pix_w-1:0] rgb,
        output logic hsync_n,
        output logic vsync_n,
        output logic blank,
        output logic underflow
);
        import video_pkg::*;

        logic active;

        // ====================================================================
        // Active window and pop
        // ====================================================================

        // Visible lines only, right half of the horizontal count
        assign active = !tim.vblk && (tim.h_cnt >= h_active_first);

        // The raster never waits so an empty FIFO just skips the pop
        assign fq.pop = active && !fq.empty;

        // ====================================================================
        // Registered video outputs
        // ====================================================================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rgb <= '0;
                        hsync_n <= 1'b1;
                        vsync_n <= 1'b1;
                        blank <= 1'b1;
                        underflow <= 1'b0;
                end else begin
                        // Black outside the window and on a starved pixel
                        if (active && !fq.empty) begin
                                rgb <= fq.pixel;
                        end else begin
                                rgb <= '0;
                        end

                        // Syncs pass through with the same one clock delay
                        hsync_n <= tim.hsync_n;
                        vsync_n <= tim.vsync_n;

                        blank <= !active;

                        // Flags each visible pixel that had no data behind it
                        underflow <= active && fq.empty;
                end
        end

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
/* Host side line FIFO with credit return. One credit pulse follows every pop.
   The host holds fifo_depth credits after reset and never writes without one */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
        input  logic clk,
        input  logic rst_n,
        input  logic in_valid,
        input  logic [video_pkg::pix_w-1:0] in_pixel,
        output logic credit,
        pixel_fifo_if.fifo fq
);
        import video_pkg::*;

        // Storage carries only payload
        logic [pix_w-1:0] mem [fifo_depth];

        logic [fifo_aw-1:0] wr_ptr;
        logic [fifo_aw-1:0] rd_ptr;
        logic [fifo_aw:0] count;

        // ====================================================================
        // Storage
        // ====================================================================

        // The host never writes into a full buffer
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        mem[wr_ptr] <= in_pixel;
                end
        end

        // ====================================================================
        // Pointers and occupancy
        // ====================================================================

        // Depth is a power of two so the pointers wrap on their own
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (in_valid) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (fq.pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        // Write and pop in one cycle leave the level unchanged
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count <= '0;
                end else begin
                        case ({in_valid, fq.pop})
                        2'b10: count <= count + 1'b1;
                        2'b01: count <= count - 1'b1;
                        default: count <= count;
                        endcase
                end
        end

        // A freed slot goes back to the host one clock after the pop
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        credit <= 1'b0;
                end else begin
                        credit <= fq.pop;
                end
        end

        // Head entry reads straight out of storage
        assign fq.pixel = mem[rd_ptr];
        assign fq.empty = (count == '0);
        assign fq.level = count;

endmodule

`default_nettype wire

// File: src/video_timing.sv
/* Arcade raster generator with two 9-bit counters plus derived blank and syncs.
   Drives the timing interface toward the output stage */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
        input  logic clk,
        input  logic rst_n,
        timing_if.src tim
);
        import video_pkg::*;

        logic [cnt_w-1:0] h_cnt;
        logic [cnt_w-1:0] v_cnt;
        logic vblk;

        // ====================================================================
        // Horizontal counter
        // ====================================================================

        // Free running every clock, 128..511 then back to 128
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        h_cnt <= h_start;
                end else if (h_cnt == h_last) begin
                        h_cnt <= h_start;
                end else begin
                        h_cnt <= h_cnt + 1'b1;
                end
        end

        // ====================================================================
        // Vertical counter and blank
        // ====================================================================

        // One step per line, taken at a fixed horizontal position
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        v_cnt <= v_start;
                end else if (h_cnt == h_vstep) begin
                        if (v_cnt == v_last) begin
                                v_cnt <= v_start;
                        end else begin
                                v_cnt <= v_cnt + 1'b1;
                        end
                end
        end

        // Blank changes only at the update point and holds otherwise
        // It compares against the line number still held in the register
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        vblk <= 1'b1;
                end else if (h_cnt == h_vblk_upd) begin
                        if (v_cnt == v_blank_off) begin
                                vblk <= 1'b0;
                        end else if (v_cnt == v_blank_on) begin
                                vblk <= 1'b1;
                        end
                end
        end

        // ====================================================================
        // Outputs straight from the counter registers
        // ====================================================================

        assign tim.h_cnt = h_cnt;
        assign tim.v_cnt = v_cnt;
        assign tim.vblk = vblk;

        // Sync pulse covers counts 176..207
        assign tim.hsync_n = !((h_cnt >= hsync_first) && (h_cnt <= hsync_last));

        // Lines 248..255 are the only ones with the top bit clear
        assign tim.vsync_n = v_cnt[cnt_w-1];

endmodule

`default_nettype wire

// File: src/pixel_fifo_if.sv
/* Pop request and head pixel between the line FIFO and the output stage */
`timescale 1ns/1ps
`default_nettype none

interface pixel_fifo_if;
        import video_pkg::*;

        // Consumer asks for the head entry, only while empty is low
        logic pop;

        // Head entry, valid whenever empty is low
        logic [pix_w-1:0] pixel;
        logic empty;

        // Occupancy in entries, 0..fifo_depth
        logic [fifo_aw:0] level;

        // FIFO side
        modport fifo (input pop, output pixel, empty, level);

        // Output stage side
        modport consumer (output pop, input pixel, empty, level);

endinterface

`default_nettype wire

// File: src/timing_if.sv
/* Raster position and timing flags from the timing generator to the output stage */
`timescale 1ns/1ps
`default_nettype none

interface timing_if;
        import video_pkg::*;

        // Raw raster counters
        logic [cnt_w-1:0] h_cnt;
        logic [cnt_w-1:0] v_cnt;

        // Derived flags, syncs are active low
        logic vblk;
        logic hsync_n;
        logic vsync_n;

        // Generator side
        modport src (output h_cnt, v_cnt, vblk, hsync_n, vsync_n);

        // Output stage side
        modport dst (input h_cnt, v_cnt, vblk, hsync_n, vsync_n);

endinterface

`default_nettype wire

// File: src/video_pkg.sv
/* Raster limits, sync and blank boundaries, pixel width and FIFO size shared by the
   video subsystem and its testbench */
`default_nettype none

package video_pkg;

        // ====================================================================
        // Data path sizes
        // ====================================================================

        localparam int pix_w = 16;
        localparam int cnt_w = 9;

        // Sixteen entries give the host enough slack to cover a full burst
        localparam int fifo_depth = 16;
        localparam int fifo_aw = 4;

        // ====================================================================
        // Raster counters
        // ====================================================================

        // Horizontal runs 128..511 for 384 clocks per line
        localparam logic [cnt_w-1:0] h_start = 9'd128;
        localparam logic [cnt_w-1:0] h_last = 9'd511;

        // Vertical runs 248..511 for 264 lines per frame
        localparam logic [cnt_w-1:0] v_start = 9'd248;
        localparam logic [cnt_w-1:0] v_last = 9'd511;

        // The horizontal counter never holds a value below h_start
        // So the line step shares the edge with the blank update at sync start
        localparam logic [cnt_w-1:0] h_vstep = 9'd176;
        localparam logic [cnt_w-1:0] h_vblk_upd = 9'd176;

        // Blank looks at the line number before the step
        // This leaves lines 272..495 visible
        localparam logic [cnt_w-1:0] v_blank_off = 9'd271;
        localparam logic [cnt_w-1:0] v_blank_on = 9'd495;

        // Horizontal sync is 32 clocks wide
        localparam logic [cnt_w-1:0] hsync_first = 9'd176;
        localparam logic [cnt_w-1:0] hsync_last = 9'd207;

        // Visible pixels occupy the upper half of the horizontal count
        localparam logic [cnt_w-1:0] h_active_first = 9'd256;

endpackage

`default_nettype wire
